/* build.f */
source/capture_pkg.sv
source/fifo_pkg.sv
source/capture_ctrl.sv
source/fill_counter.sv
source/word_packer.sv
source/sample_fifo.sv
source/preddr_packer_top.sv
tests/preddr_packer_asserts.sv
tests/preddr_packer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the packer testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module preddr_packer_tb \
  -f build.f -o preddr_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/preddr_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "failure found in sim.log"
  exit 1
fi
exit 0

/* tests/preddr_packer_tb.sv */
`timescale 1ns/1ps

module preddr_packer_tb import capture_pkg::*, fifo_pkg::*; ();

  typedef sample_t   sample_q_t[$];
  typedef ddr_word_t word_q_t[$];

  logic          wr_clk;
  logic          reset;
  logic          enabled;
  logic          capture_start;
  logic          flush;
  logic          sample_wr;
  sample_t       sample;
  capture_mode_e mode;
  logic          fifo_rd = 1'b0;
  ddr_word_t     fifo_dout;
  fifo_status_t  status;

  integer    seed = 11;
  bit        auto_read = 0;  // compare process pops words only when set
  bit        rd_req = 0;     // becomes fifo_rd at the next rising edge
  bit        manual_rd = 0;  // single read driven by the main sequence
  sample_q_t tx_q;
  word_q_t   exp_q;

  preddr_packer_top #(.FIFO_DEPTH_LOG2(5)) uut (
    .wr_clk (wr_clk), .reset (reset), .enabled (enabled),
    .capture_start (capture_start), .flush (flush), .sample_wr (sample_wr),
    .sample (sample), .mode (mode), .fifo_rd (fifo_rd),
    .fifo_dout (fifo_dout), .status (status)
  );

  always #10 wr_clk = ~wr_clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input ddr_word_t got, input ddr_word_t exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("Error at %0t: %s got %h, expected %h",
                                  $time, what, got, exp));
  endtask

  task automatic check_status(input fifo_status_t got, input fifo_status_t exp,
                              input string what);
    if (got !== exp)
      stop_with_failure($sformatf("Error at %0t: %s status got %b, expected %b",
                                  $time, what, got, exp));
  endtask

  function automatic fifo_status_t make_status(input logic full, input logic empty,
                                               input logic ovf, input logic udf,
                                               input logic half);
    fifo_status_t s;
    s.full       = full;
    s.empty      = empty;
    s.overflow   = ovf;
    s.underflow  = udf;
    s.level_half = half;
    return s;
  endfunction

  // msb-first bit stream cut into 64-bit words; a partial tail is dropped
  function automatic word_q_t pack_words(input sample_q_t s, input capture_mode_e m);
    word_q_t   words;
    logic      bits[$];
    ddr_word_t w;
    int        width;
    width = (m == mode_4bit) ? 8 : 18;
    foreach (s[i]) begin
      for (int b = width - 1; b >= 0; b--)
        bits.push_back(s[i].full[b]);
      if (bits.size() >= 64) begin
        w = '0;
        for (int b = 0; b < 64; b++)
          w = {w[62:0], bits.pop_front()};
        words.push_back(w);
      end
    end
    return words;
  endfunction

  task automatic make_samples(input int n, input capture_mode_e m);
    sample_t  s;
    word_q_t  w;
    tx_q.delete();
    for (int i = 0; i < n; i++) begin
      s.full = 18'($random(seed));
      tx_q.push_back(s);
    end
    w = pack_words(tx_q, m);
    foreach (w[i])
      exp_q.push_back(w[i]);
  endtask

  task automatic send_samples(input bit gaps);
    sample_t s;
    int      gap;
    while (tx_q.size() > 0) begin
      s = tx_q.pop_front();
      @(posedge wr_clk);
      sample_wr <= 1'b1;
      sample    <= s;
      gap = gaps ? ($random(seed) & 32'd3) : 0;
      repeat (gap) begin
        @(posedge wr_clk);
        sample_wr <= 1'b0;
      end
    end
    @(posedge wr_clk);
    sample_wr <= 1'b0;
  endtask

  task automatic pulse_capture_start();
    @(posedge wr_clk);
    capture_start <= 1'b1;
    @(posedge wr_clk);
    capture_start <= 1'b0;
  endtask

  task automatic wait_empty_is(input logic level, input int limit, input string what);
    int n = 0;
    while (status.empty !== level) begin
      @(negedge wr_clk);
      n++;
      if (n > limit)
        stop_with_failure({"timed out waiting for ", what});
    end
  endtask

  task automatic wait_flags(input fifo_status_t mask, input int limit, input string what);
    int n = 0;
    while ((status & mask) !== mask) begin
      @(negedge wr_clk);
      n++;
      if (n > limit)
        stop_with_failure({"timed out waiting for ", what});
    end
  endtask

  task automatic wait_drained(input int limit, input string what);
    int n = 0;
    while (exp_q.size() != 0 || fifo_rd || rd_req) begin
      @(negedge wr_clk);
      n++;
      if (n > limit)
        stop_with_failure({"expected words never came out after ", what});
    end
  endtask

  // checks the head word and pops it every other cycle while words wait
  always @(negedge wr_clk) begin
    rd_req = 1'b0;
    if (!reset && auto_read && !status.empty && !fifo_rd) begin
      if (exp_q.size() == 0)
        stop_with_failure("the FIFO held a word that no test expected");
      else begin
        check_word(fifo_dout, exp_q.pop_front(), "fifo word");
        rd_req = 1'b1;
      end
    end
  end

  always @(posedge wr_clk) begin
    fifo_rd <= rd_req || manual_rd;
  end

  initial begin
    #5_000_000;
    stop_with_failure("simulation ran past its overall time limit");
  end

  initial begin
    wr_clk = 0;
    reset = 1;
    enabled = 0;
    capture_start = 0;
    flush = 0;
    sample_wr = 0;
    sample = '0;
    mode = mode_18bit;
    repeat (5) @(posedge wr_clk);
    reset <= 1'b0;
    @(negedge wr_clk);
    check_status(status, make_status(0, 1, 0, 0, 0), "after reset");
    @(posedge wr_clk);
    enabled <= 1'b1;
    repeat (3) @(posedge wr_clk);
    auto_read = 1;

    make_samples(32, mode_18bit);           // 18-bit packing gives 9 words
    if (exp_q.size() != 9)
      stop_with_failure("reference did not give 9 words for 32 samples");
    send_samples(1);
    wait_drained(400, "18-bit packing");

    @(posedge wr_clk);
    mode <= mode_4bit;                      // 4-bit packing gives 8 words
    make_samples(64, mode_4bit);
    send_samples(0);
    wait_drained(400, "4-bit packing");

    @(posedge wr_clk);
    mode <= mode_18bit;                     // restart in the middle of a word
    make_samples(10, mode_18bit);
    send_samples(1);
    repeat (2) @(posedge wr_clk);
    pulse_capture_start();
    make_samples(32, mode_18bit);
    send_samples(1);
    wait_drained(400, "capture restart");

    auto_read = 0;                          // flush drains without reads
    make_samples(8, mode_18bit);
    exp_q.delete();
    send_samples(0);
    wait_empty_is(1'b0, 50, "words before flush");
    @(posedge wr_clk);
    flush <= 1'b1;
    wait_empty_is(1'b1, 100, "flush to finish");
    @(posedge wr_clk);
    flush <= 1'b0;
    repeat (2) @(negedge wr_clk);
    check_status(status, make_status(0, 1, 0, 0, 0), "after flush");
    pulse_capture_start();

    @(posedge wr_clk);
    mode <= mode_4bit;                      // 40 words into a 32-word FIFO
    make_samples(320, mode_4bit);
    while (exp_q.size() > 32)
      void'(exp_q.pop_back());
    send_samples(0);
    wait_flags(make_status(1, 0, 1, 0, 0), 100, "overflow");
    repeat (4) @(negedge wr_clk);
    check_status(status, make_status(1, 0, 1, 0, 1), "after overflow");
    auto_read = 1;
    wait_drained(400, "overflow readout");
    auto_read = 0;
    @(negedge wr_clk);
    manual_rd = 1'b1;                       // read while empty
    @(negedge wr_clk);
    manual_rd = 1'b0;
    wait_flags(make_status(0, 0, 0, 1, 0), 20, "underflow");
    @(negedge wr_clk);
    check_status(status, make_status(0, 1, 1, 1, 0), "after underflow");

    auto_read = 1;                          // disabled capture takes nothing
    @(posedge wr_clk);
    enabled <= 1'b0;
    make_samples(64, mode_4bit);
    exp_q.delete();
    send_samples(0);
    if (status.empty !== 1'b1)
      stop_with_failure("status.empty was low while the packer was disabled");
    @(posedge wr_clk);
    enabled <= 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(negedge wr_clk);
      if (status.empty !== 1'b1)
        stop_with_failure("a word appeared after re-enable");
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* tests/preddr_packer_asserts.sv */
`timescale 1ns/1ps

module preddr_packer_asserts import capture_pkg::*; (
  input logic        wr_clk,
  input logic        reset,
  input logic        wr,
  input logic        full,
  input logic        ovf,
  input ctrl_state_e state,
  input logic        pop
);

  // a word offered while full must show up as overflow one cycle later
  property p_write_when_full;
    @(posedge wr_clk) disable iff (reset) (wr && full) |=> ovf;
  endproperty

  property p_no_pop_when_off;
    @(posedge wr_clk) disable iff (reset) (state == st_off) |-> !pop;
  endproperty

  property p_overflow_sticky;
    @(posedge wr_clk) disable iff (reset) ovf |=> ovf;
  endproperty

  a_write_when_full: assert property (p_write_when_full)
    else $error("word written while full without overflow");
  a_no_pop_when_off: assert property (p_no_pop_when_off)
    else $error("pop high in st_off");
  a_overflow_sticky: assert property (p_overflow_sticky)
    else $error("overflow dropped without reset");

endmodule

// FIFO side, controller ports tied off
bind sample_fifo preddr_packer_asserts u_fifo_asserts (
  .wr_clk (wr_clk), .reset (reset), .wr (wr), .full (full_raw), .ovf (ovf),
  .state (capture_pkg::st_run), .pop (1'b0)
);

// controller side, FIFO ports tied off
bind capture_ctrl preddr_packer_asserts u_ctrl_asserts (
  .wr_clk (wr_clk), .reset (reset), .wr (1'b0), .full (1'b0), .ovf (1'b0),
  .state (state), .pop (pop)
);

/* source/preddr_packer_top.sv */
`timescale 1ns/1ps

module preddr_packer_top import capture_pkg::*, fifo_pkg::*; #(
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  logic          wr_clk,
  input  logic          reset,
  input  logic          enabled,
  input  logic          capture_start,
  input  logic          flush,
  input  logic          sample_wr,
  input  sample_t       sample,
  input  capture_mode_e mode,
  input  logic          fifo_rd,
  output ddr_word_t     fifo_dout,
  output fifo_status_t  status
);

  logic        clear;
  logic        accept;
  logic        pop;
  logic        sample_acc;  // strobe after the controller lets it through
  logic        word_wr;
  fill_phase_t phase;
  ddr_word_t   word;

  assign sample_acc = sample_wr && accept;

  capture_ctrl u_ctrl (
    .wr_clk        (wr_clk),
    .reset         (reset),
    .enabled       (enabled),
    .capture_start (capture_start),
    .flush         (flush),
    .fifo_rd       (fifo_rd),
    .fifo_empty    (status.empty),
    .clear         (clear),
    .accept        (accept),
    .pop           (pop)
  );

  fill_counter u_fill (
    .wr_clk    (wr_clk),
    .reset     (reset),
    .clear     (clear),
    .sample_wr (sample_acc),
    .mode      (mode),
    .phase     (phase)
  );

  word_packer u_packer (
    .wr_clk    (wr_clk),
    .reset     (reset),
    .clear     (clear),
    .sample_wr (sample_acc),
    .mode      (mode),
    .sample    (sample),
    .phase     (phase),
    .word      (word),
    .word_wr   (word_wr)
  );

  sample_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_fifo (
    .wr_clk  (wr_clk),
    .reset   (reset),
    .enabled (enabled),
    .wr      (word_wr),
    .din     (word),
    .rd      (pop),
    .dout    (fifo_dout),
    .status  (status)
  );

endmodule

/* source/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo import fifo_pkg::*; #(
  parameter int FIFO_DEPTH_LOG2 = 5
) (
  input  logic         wr_clk,
  input  logic         reset,
  input  logic         enabled,
  input  logic         wr,
  input  ddr_word_t    din,
  input  logic         rd,
  output ddr_word_t    dout,
  output fifo_status_t status
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
  localparam logic [FIFO_DEPTH_LOG2:0] LEVEL_FULL = {1'b1, {FIFO_DEPTH_LOG2{1'b0}}};
  localparam logic [FIFO_DEPTH_LOG2:0] LEVEL_HALF =
    {2'b01, {(FIFO_DEPTH_LOG2-1){1'b0}}};

  ddr_word_t mem [DEPTH];

  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;   // one extra bit to tell full from empty
  logic                       full_raw;
  logic                       empty_raw;
  logic                       do_wr;
  logic                       do_rd;
  logic                       ovf;
  logic                       udf;

  assign full_raw  = (count == LEVEL_FULL);
  assign empty_raw = (count == '0);
  assign do_wr     = wr && !full_raw;   // words arriving while full are lost
  assign do_rd     = rd && !empty_raw;

  always_ff @(posedge wr_clk) begin
    if (do_wr)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge wr_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
      udf    <= 1'b0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
      if (wr && full_raw)
        ovf <= 1'b1;
      if (rd && empty_raw)
        udf <= 1'b1;
    end
  end

  assign dout = mem[rd_ptr];  // head word shows without a read

  always_comb begin
    status.full       = full_raw;
    status.empty      = empty_raw || !enabled;  // reads as empty while disabled
    status.overflow   = ovf;
    status.underflow  = udf;
    status.level_half = (count >= LEVEL_HALF);
  end

endmodule

/* source/word_packer.sv */
`timescale 1ns/1ps

module word_packer import capture_pkg::*, fifo_pkg::*; (
  input  logic          wr_clk,
  input  logic          reset,
  input  logic          clear,
  input  logic          sample_wr,
  input  capture_mode_e mode,
  input  sample_t       sample,
  input  fill_phase_t   phase,
  output ddr_word_t     word,
  output logic          word_wr
);

  // worst case holds 63 leftover bits plus one full sample
  localparam int SHIFT_BITS = WORD_BITS + SAMPLE_BITS;

  logic [SHIFT_BITS-1:0] shifter;  // newest sample sits in the low bits

  always_ff @(posedge wr_clk) begin
    if (clear) begin
      shifter <= '0;
    end else if (sample_wr) begin
      if (mode == mode_4bit)
        shifter <= {shifter[SHIFT_BITS-NIB_BITS-1:0], sample.nib.pair};
      else
        shifter <= {shifter[SHIFT_BITS-SAMPLE_BITS-1:0], sample.full};
    end
  end

  // phase lags the shifter by one edge, so fill_bits already counts what
  // stays behind; the word is the 64 bits just above those leftovers
  always_ff @(posedge wr_clk) begin
    if (phase.word_ready)
      word <= ddr_word_t'(shifter >> phase.fill_bits);
  end

  always_ff @(posedge wr_clk) begin
    if (reset)
      word_wr <= 1'b0;
    else
      word_wr <= phase.word_ready && !clear;  // restart drops a word in flight
  end

endmodule

/* source/fill_counter.sv */
`timescale 1ns/1ps

module fill_counter import capture_pkg::*; (
  input  logic          wr_clk,
  input  logic          reset,
  input  logic          clear,
  input  logic          sample_wr,
  input  capture_mode_e mode,
  output fill_phase_t   phase
);

  logic [7:0] step;      // stream bits added by one sample
  logic [7:0] sum;       // pending bits including the new sample
  logic       word_done;

  always_comb begin
    if (mode == mode_4bit)
      step = 8'(NIB_BITS);
    else
      step = 8'(SAMPLE_BITS);
  end

  assign sum       = {1'b0, phase.fill_bits} + step;  // at most 63 + 18
  assign word_done = (sum >= 8'd64);

  // a word leaves as soon as 64 bits are pending and the rest carries over
  always_ff @(posedge wr_clk) begin
    if (reset || clear) begin
      phase.fill_bits  <= '0;
      phase.word_ready <= 1'b0;
    end else if (sample_wr) begin
      phase.word_ready <= word_done;
      if (word_done)
        phase.fill_bits <= 7'(sum - 8'd64);
      else
        phase.fill_bits <= sum[6:0];
    end else begin
      phase.word_ready <= 1'b0;  // ready is a single-cycle flag
    end
  end

endmodule

/* source/capture_ctrl.sv */
`timescale 1ns/1ps

module capture_ctrl import capture_pkg::*; (
  input  logic wr_clk,
  input  logic reset,
  input  logic enabled,
  input  logic capture_start,
  input  logic flush,
  input  logic fifo_rd,
  input  logic fifo_empty,
  output logic clear,
  output logic accept,
  output logic pop
);

  ctrl_state_e state;
  ctrl_state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      st_off: begin
        if (enabled)
          state_next = st_run;
      end
      st_run: begin
        if (!enabled)
          state_next = st_off;
        else if (flush)
          state_next = st_flush;
      end
      st_flush: begin
        // drain until the FIFO reports empty, then go back to where enabled says
        if (fifo_empty)
          state_next = enabled ? st_run : st_off;
      end
      default: state_next = st_off;
    endcase
  end

  always_ff @(posedge wr_clk) begin
    if (reset)
      state <= st_off;
    else
      state <= state_next;
  end

  // clear on restart, on the way into off, and for as long as we sit in off
  assign clear = (state == st_off) || (state_next == st_off) || capture_start;

  assign accept = (state == st_run);  // no samples taken while flushing

  // user reads plus one pop per cycle while flushing
  assign pop = fifo_rd || ((state == st_flush) && !fifo_empty);

endmodule

/* source/fifo_pkg.sv */
package fifo_pkg;

  localparam int WORD_BITS = 64;  // DDR write width

  typedef logic [WORD_BITS-1:0] ddr_word_t;

  // overflow and underflow stay set until reset
  typedef struct packed {
    logic full;
    logic empty;
    logic overflow;
    logic underflow;
    logic level_half;
  } fifo_status_t;

endpackage

/* source/capture_pkg.sv */
package capture_pkg;

  localparam int SAMPLE_BITS = 18;  // full capture sample
  localparam int NIB_BITS    = 8;   // two 4-bit samples packed in the low byte

  // 4-bit capture only carries the low byte of each sample
  typedef struct packed {
    logic [9:0] unused;
    logic [7:0] pair;    // two nibbles, older one on top
  } nib_pair_t;

  // one capture sample, read either whole or as a nibble pair
  typedef union packed {
    logic [SAMPLE_BITS-1:0] full;
    nib_pair_t              nib;
  } sample_t;

  typedef enum logic {
    mode_18bit = 1'b0,
    mode_4bit  = 1'b1
  } capture_mode_e;

  typedef enum logic [1:0] {
    st_off   = 2'd0,
    st_run   = 2'd1,
    st_flush = 2'd2
  } ctrl_state_e;

  // pending stream bits after the latest sample, plus the word-complete flag
  typedef struct packed {
    logic [6:0] fill_bits;
    logic       word_ready;
  } fill_phase_t;

endpackage
